// File: hw/bht_consts.svh
`ifndef BHT_CONSTS_SVH
`define BHT_CONSTS_SVH

// table geometry
`define BHT_SETS 16
`define BHT_WAYS 4
`define BHT_WAY_W 2

// halfword program counter, split as {tag, set}
`define PC_W 11
`define SET_W 4
`define TAG_W 7

// saturating counter
`define CNT_W 2

// one entry is valid + {isr, tag} + target + counter
`define BHT_ENTRY_W (1 + (`TAG_W + 1) + `PC_W + `CNT_W)
`define BHT_LINE_W (`BHT_ENTRY_W * `BHT_WAYS)

`endif

// File: hw/bp_pkg.sv
`include "bht_consts.svh"

package bp_pkg;

	////////////////////
	// table entry
	////////////////////

	// msb of the tag is the interrupt-mode bit, the rest is pc[10:4]
	typedef struct packed {
		logic               valid;
		logic [`TAG_W:0]    tag;
		logic [`PC_W-1:0]   target;
		logic [`CNT_W-1:0]  cnt;
	} bht_entry_t;

	// one set of the table
	// per-way view for lookups, raw view for masked writes
	typedef union packed {
		bht_entry_t [`BHT_WAYS-1:0] way;
		logic [`BHT_LINE_W-1:0]     raw;
	} bht_line_u;

	////////////////////
	// fetch correction
	////////////////////

	// code 1 is never produced, the fetch mux treats it like none
	typedef enum logic [1:0] {
		CORR_NONE = 2'd0,
		CORR_CNI  = 2'd2,
		CORR_PBT  = 2'd3
	} corr_t;

endpackage

// File: hw/bht_hit_if.sv
`include "bht_consts.svh"

// result of one table read port, valid in the cycle of its pc
interface bht_hit_if;

	// single matching way found
	logic                  hit;
	// way index of the match, 0 on a miss
	logic [`BHT_WAY_W-1:0] way;
	// matching entry, all zeros on a miss
	bp_pkg::bht_entry_t    entry;
	// set index taken from the pc
	logic [`SET_W-1:0]     set;

	// lookup side
	modport src (
		output hit, way, entry, set
	);

	// consumers in execute and decode
	modport dst (
		input hit, way, entry, set
	);

endinterface

// File: hw/bht_lookup.sv
`include "bht_consts.svh"

module bht_lookup (
	input  logic [`PC_W-1:0] pc,
	input  logic             isr,
	input  bp_pkg::bht_line_u line,
	bht_hit_if.src           res
);

	// compare key, interrupt mode on top of the pc tag
	logic [`TAG_W:0]      key;
	// per-way tag match qualified by valid
	logic [`BHT_WAYS-1:0] match;

	assign key = {isr, pc[`PC_W-1:`SET_W]};

	// set index goes out unchanged, execute needs it for the cni
	assign res.set = pc[`SET_W-1:0];

	////////////////////
	// tag compare
	////////////////////

	always_comb begin
		for (int w = 0; w < `BHT_WAYS; w++) begin
			match[w] = line.way[w].valid && (line.way[w].tag == key);
		end
	end

	////////////////////
	// way select
	////////////////////

	// only a clean one-hot match counts as a hit
	// anything else reads as a miss with a zero entry
	always_comb begin
		res.hit   = 1'b0;
		res.way   = '0;
		res.entry = '0;
		if ($onehot(match)) begin
			for (int w = 0; w < `BHT_WAYS; w++) begin
				if (match[w]) begin
					res.hit   = 1'b1;
					res.way   = `BHT_WAY_W'(w);
					res.entry = line.way[w];
				end
			end
		end
	end

	// the store only allocates on a miss, so one pc never owns two ways of a set
	always_comb begin
		a_single_way: assert ($onehot0(match))
			else $error("bht_lookup: pc %0h matches ways %b", pc, match);
	end

endmodule

// File: hw/bht_store.sv
`include "bht_consts.svh"

module bht_store (
	input  logic             CLK,
	input  logic             nrst,
	input  logic             en,
	input  logic             stall,
	input  logic             isr_running,
	input  logic [`PC_W-1:0] if_pc,
	input  logic [`PC_W-1:0] id_pc,
	input  logic [`PC_W-1:0] exe_pc,
	input  logic [`PC_W-1:0] id_target,
	input  logic             id_is_jump,
	input  logic             id_is_btype,
	input  logic             id_sel_opbr,
	input  logic             exe_active,
	input  logic             exe_taken,
	bht_hit_if.src           if_hit,
	bht_hit_if.src           id_hit,
	bht_hit_if.src           exe_hit
);

	// 16 lines of 4 entries, plus one fifo pointer per set
	bp_pkg::bht_line_u     table_q [`BHT_SETS];
	logic [`BHT_WAY_W-1:0] fifo_q [`BHT_SETS];

	logic [`SET_W-1:0]      id_set;
	logic [`SET_W-1:0]      exe_set;
	logic                   do_alloc;
	logic                   do_retarget;
	logic                   do_train;
	logic                   wr_train;
	logic [`CNT_W-1:0]      trained_cnt;
	logic [`SET_W-1:0]      wr_set;
	logic [`BHT_WAY_W-1:0]  wr_way;
	bp_pkg::bht_entry_t     wr_entry;
	logic [`BHT_LINE_W-1:0] wr_mask;
	logic [`BHT_LINE_W-1:0] wr_data;

	assign id_set  = id_pc[`SET_W-1:0];
	assign exe_set = exe_pc[`SET_W-1:0];

	////////////////////
	// read ports
	////////////////////

	// fetch predicts
	bht_lookup u_if_lookup (
		.pc   (if_pc),
		.isr  (isr_running),
		.line (table_q[if_pc[`SET_W-1:0]]),
		.res  (if_hit)
	);

	// decode allocates and retargets
	bht_lookup u_id_lookup (
		.pc   (id_pc),
		.isr  (isr_running),
		.line (table_q[id_set]),
		.res  (id_hit)
	);

	// execute trains
	bht_lookup u_exe_lookup (
		.pc   (exe_pc),
		.isr  (isr_running),
		.line (table_q[exe_set]),
		.res  (exe_hit)
	);

	////////////////////
	// write select
	////////////////////

	// priority is allocate, then retarget, then train
	assign do_alloc    = (id_is_jump || id_is_btype) && !id_hit.hit;
	assign do_retarget = id_is_jump && id_sel_opbr && id_hit.hit
		&& (id_target != id_hit.entry.target);
	assign do_train    = exe_active && exe_hit.hit;
	assign wr_train    = en && !stall && do_train && !do_alloc && !do_retarget;

	// saturating step of the execute counter
	always_comb begin
		trained_cnt = exe_hit.entry.cnt;
		if (exe_taken && (exe_hit.entry.cnt != '1))
			trained_cnt = exe_hit.entry.cnt + 1'b1;
		else if (!exe_taken && (exe_hit.entry.cnt != '0))
			trained_cnt = exe_hit.entry.cnt - 1'b1;
	end

	always_comb begin
		wr_set   = id_set;
		wr_way   = fifo_q[id_set];
		wr_entry = '0;
		if (do_alloc) begin
			// new entry, jumps start strongly taken, branches weakly not taken
			wr_entry.valid  = 1'b1;
			wr_entry.tag    = {isr_running, id_pc[`PC_W-1:`SET_W]};
			wr_entry.target = id_target;
			wr_entry.cnt    = id_is_jump ? `CNT_W'(3) : `CNT_W'(1);
		end else if (do_retarget) begin
			wr_way          = id_hit.way;
			wr_entry        = id_hit.entry;
			wr_entry.target = id_target;
		end else if (do_train) begin
			wr_set       = exe_set;
			wr_way       = exe_hit.way;
			wr_entry     = exe_hit.entry;
			wr_entry.cnt = trained_cnt;
		end
	end

	// place the entry into its way of the raw line
	assign wr_mask = `BHT_LINE_W'({`BHT_ENTRY_W{1'b1}}) << (wr_way * `BHT_ENTRY_W);
	assign wr_data = `BHT_LINE_W'(wr_entry) << (wr_way * `BHT_ENTRY_W);

	////////////////////
	// table update
	////////////////////

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			for (int s = 0; s < `BHT_SETS; s++) begin
				table_q[s] <= '0;
				fifo_q[s]  <= '0;
			end
		end else if (en && !stall) begin
			if (do_alloc || do_retarget || do_train)
				table_q[wr_set].raw <= (table_q[wr_set].raw & ~wr_mask) | wr_data;
			// pointer wraps naturally over the four ways
			if (do_alloc)
				fifo_q[id_set] <= fifo_q[id_set] + 1'b1;
		end
	end

	// a stalled cycle leaves both writable sets untouched
	a_no_write_stalled: assert property (@(posedge CLK) disable iff (!nrst)
		stall |=> (table_q[$past(id_set)] == $past(table_q[id_set]))
			&& (table_q[$past(exe_set)] == $past(table_q[exe_set])));

	// a trained counter never wraps around between 0 and 3
	property p_no_wrap(logic [`CNT_W-1:0] from, logic [`CNT_W-1:0] to);
		@(posedge CLK) disable iff (!nrst)
		(wr_train && (exe_hit.entry.cnt == from)) |=>
			(table_q[$past(exe_set)].way[$past(exe_hit.way)].cnt != to);
	endproperty

	a_no_wrap_up: assert property (p_no_wrap(`CNT_W'(3), `CNT_W'(0)));
	a_no_wrap_dn: assert property (p_no_wrap(`CNT_W'(0), `CNT_W'(3)));

endmodule

// File: hw/branch_resolve.sv
`include "bht_consts.svh"

module branch_resolve (
	input  logic             [5:0] exe_btype,
	input  logic             [1:0] exe_c_btype,
	input  logic                   exe_z,
	input  logic                   exe_less,
	bht_hit_if.dst                 hit,
	output logic                   exe_active,
	output logic                   exe_taken,
	output bp_pkg::corr_t          exe_correction,
	output logic       [`PC_W-1:0] exe_pbt,
	output logic       [`PC_W-1:0] exe_cni,
	output logic                   mispredict
);

	// branch kind one-hots from decode
	logic is_beq;
	logic is_bne;
	logic is_blt;
	logic is_bge;
	logic is_bltu;
	logic is_bgeu;
	logic is_beqz;
	logic is_bnez;

	assign is_beq  = exe_btype[5];
	assign is_bne  = exe_btype[4];
	assign is_blt  = exe_btype[3];
	assign is_bge  = exe_btype[2];
	assign is_bltu = exe_btype[1];
	assign is_bgeu = exe_btype[0];
	assign is_beqz = exe_c_btype[1];
	assign is_bnez = exe_c_btype[0];

	////////////////////
	// outcome
	////////////////////

	// the alu sets less for signed or unsigned compare as the opcode asks
	assign exe_taken = (is_beq && exe_z) || (is_bne && !exe_z)
		|| (is_blt && exe_less) || (is_bge && !exe_less)
		|| (is_bltu && exe_less) || (is_bgeu && !exe_less)
		|| (is_beqz && exe_z) || (is_bnez && !exe_z);

	assign exe_active = (|exe_btype) || (|exe_c_btype);

	// on a miss the entry is zero, so the branch counts as predicted not taken
	assign mispredict = exe_active && (exe_taken != hit.entry.cnt[1]);

	////////////////////
	// correction
	////////////////////

	always_comb begin
		if (!mispredict)
			exe_correction = bp_pkg::CORR_NONE;
		else if (exe_taken)
			exe_correction = bp_pkg::CORR_PBT;
		else
			exe_correction = bp_pkg::CORR_CNI;
	end

	assign exe_pbt = hit.entry.target;

	// fall-through rebuilt from the stored tag and the set
	// compressed branches are one halfword long, others two
	assign exe_cni = {hit.entry.tag[`TAG_W-1:0], hit.set}
		+ ((|exe_c_btype) ? `PC_W'(1) : `PC_W'(2));

endmodule

// File: hw/flush_ctrl.sv
`include "bht_consts.svh"

module flush_ctrl (
	input  logic             CLK,
	input  logic             nrst,
	input  logic             en,
	input  logic             stall,
	input  logic             mispredict,
	input  logic             id_is_jump,
	input  logic             id_sel_opbr,
	input  logic [`PC_W-1:0] id_target,
	bht_hit_if.dst           hit,
	output logic             flush,
	output logic             id_jump_in_bht
);

	logic flush_q;
	logic flush_d;
	logic adv;
	logic tgt_changed;
	logic jump_alloc;
	logic retarget;

	assign adv = en && !stall;

	// register jumps only, a jal target never changes
	assign tgt_changed = id_sel_opbr && (id_target != hit.entry.target);
	assign jump_alloc  = id_is_jump && !hit.hit;
	assign retarget    = id_is_jump && hit.hit && tgt_changed;

	// fetch may use the decode target directly
	assign id_jump_in_bht = id_is_jump && hit.hit && !tgt_changed;

	////////////////////
	// flush state
	////////////////////

	// mispredict flushes now and once more
	// decode jump events only arm the delayed flush
	assign flush   = flush_q || mispredict;
	assign flush_d = !flush_q && (mispredict || jump_alloc || retarget);

	always_ff @(posedge CLK) begin
		if (!nrst)
			flush_q <= 1'b0;
		else if (adv)
			flush_q <= flush_d;
	end

	// a held flush ends after one advancing cycle unless execute mispredicts again
	a_flush_len: assert property (@(posedge CLK) disable iff (!nrst)
		(adv && flush && !mispredict) |=> (!adv || !flush || mispredict));

endmodule

// File: hw/branch_predictor.sv
`include "bht_consts.svh"

module branch_predictor (
	input  logic             CLK,
	input  logic             nrst,
	input  logic             en,
	input  logic             isr_running,
	input  logic             stall,

	// fetch
	input  logic [`PC_W-1:0] if_pc,

	// decode
	input  logic [`PC_W-1:0] id_pc,
	input  logic [`PC_W-1:0] id_branchtarget,
	input  logic             id_is_jump,
	input  logic             id_is_btype,
	input  logic             id_sel_opbr,

	// execute, flags come from the alu
	input  logic [`PC_W-1:0] exe_pc,
	input  logic             exe_z,
	input  logic             exe_less,
	input  logic [5:0]       exe_btype,
	input  logic [1:0]       exe_c_btype,

	// next-pc select is {exe_correction, if_prediction}
	output logic             if_prediction,
	output bp_pkg::corr_t    exe_correction,
	output logic             flush,
	output logic             id_jump_in_bht,
	output logic [`PC_W-1:0] if_pbt,
	output logic [`PC_W-1:0] exe_pbt,
	output logic [`PC_W-1:0] exe_cni
);

	// one lookup result per pipeline point
	bht_hit_if if_hit ();
	bht_hit_if id_hit ();
	bht_hit_if exe_hit ();

	logic exe_active;
	logic exe_taken;
	logic mispredict;

	// miss gives a zero entry, so no prediction and a zero target
	assign if_prediction = if_hit.entry.cnt[1];
	assign if_pbt        = if_hit.entry.target;

	bht_store u_store (
		.CLK         (CLK),
		.nrst        (nrst),
		.en          (en),
		.stall       (stall),
		.isr_running (isr_running),
		.if_pc       (if_pc),
		.id_pc       (id_pc),
		.exe_pc      (exe_pc),
		.id_target   (id_branchtarget),
		.id_is_jump  (id_is_jump),
		.id_is_btype (id_is_btype),
		.id_sel_opbr (id_sel_opbr),
		.exe_active  (exe_active),
		.exe_taken   (exe_taken),
		.if_hit      (if_hit),
		.id_hit      (id_hit),
		.exe_hit     (exe_hit)
	);

	branch_resolve u_resolve (
		.exe_btype      (exe_btype),
		.exe_c_btype    (exe_c_btype),
		.exe_z          (exe_z),
		.exe_less       (exe_less),
		.hit            (exe_hit),
		.exe_active     (exe_active),
		.exe_taken      (exe_taken),
		.exe_correction (exe_correction),
		.exe_pbt        (exe_pbt),
		.exe_cni        (exe_cni),
		.mispredict     (mispredict)
	);

	flush_ctrl u_flush (
		.CLK            (CLK),
		.nrst           (nrst),
		.en             (en),
		.stall          (stall),
		.mispredict     (mispredict),
		.id_is_jump     (id_is_jump),
		.id_sel_opbr    (id_sel_opbr),
		.id_target      (id_branchtarget),
		.hit            (id_hit),
		.flush          (flush),
		.id_jump_in_bht (id_jump_in_bht)
	);

endmodule

// File: verif/bht_model.svh
`ifndef BHT_MODEL_SVH
`define BHT_MODEL_SVH

////////////////////
// model state
////////////////////

// table mirror kept as plain arrays, one per entry field
logic              m_valid  [`BHT_SETS][`BHT_WAYS];
logic [`TAG_W:0]   m_tag    [`BHT_SETS][`BHT_WAYS];
logic [`PC_W-1:0]  m_target [`BHT_SETS][`BHT_WAYS];
logic [`CNT_W-1:0] m_cnt    [`BHT_SETS][`BHT_WAYS];
// next way to fill in each set
int                m_fifo   [`BHT_SETS];
// delayed half of the flush
logic              m_flush_q;

// expected outputs for the inputs now applied
logic              e_pred;
logic [`PC_W-1:0]  e_if_pbt;
logic              e_active;
logic              e_taken;
logic              e_mispredict;
bp_pkg::corr_t     e_corr;
logic [`PC_W-1:0]  e_exe_pbt;
logic [`PC_W-1:0]  e_exe_cni;
logic              e_flush;
logic              e_jib;

function automatic void model_reset();
	for (int s = 0; s < `BHT_SETS; s++) begin
		m_fifo[s] = 0;
		for (int w = 0; w < `BHT_WAYS; w++) begin
			m_valid[s][w]  = 1'b0;
			m_tag[s][w]    = '0;
			m_target[s][w] = '0;
			m_cnt[s][w]    = '0;
		end
	end
	m_flush_q = 1'b0;
endfunction

// way holding pc in the given interrupt mode, -1 on a miss
function automatic int model_find(logic [`PC_W-1:0] pc, logic isr);
	int s;
	int found;
	s     = int'(pc[`SET_W-1:0]);
	found = -1;
	for (int w = 0; w < `BHT_WAYS; w++) begin
		if (m_valid[s][w] && (m_tag[s][w] == {isr, pc[`PC_W-1:`SET_W]}))
			found = w;
	end
	return found;
endfunction

// branch outcome from the kind and the alu flags
function automatic logic model_taken(logic [5:0] bt, logic [1:0] cbt, logic z, logic less);
	if (bt[5] || cbt[1])
		return z;
	else if (bt[4] || cbt[0])
		return !z;
	else if (bt[3] || bt[1])
		return less;
	else if (bt[2] || bt[0])
		return !less;
	return 1'b0;
endfunction

// expected outputs, read from the stimulus variables of the testbench
function automatic void model_expect();
	int                fs;
	int                fw;
	int                es;
	int                ew;
	int                is;
	int                iw;
	logic [`TAG_W-1:0] ex_tag;
	// fetch
	fs       = int'(if_pc[`SET_W-1:0]);
	fw       = model_find(if_pc, isr_running);
	e_pred   = 1'b0;
	e_if_pbt = '0;
	if (fw >= 0) begin
		e_pred   = m_cnt[fs][fw][1];
		e_if_pbt = m_target[fs][fw];
	end
	// execute, a miss predicts not taken
	es           = int'(exe_pc[`SET_W-1:0]);
	ew           = model_find(exe_pc, isr_running);
	e_active     = (exe_btype != '0) || (exe_c_btype != '0);
	e_taken      = model_taken(exe_btype, exe_c_btype, exe_z, exe_less);
	e_mispredict = e_active && e_taken;
	e_exe_pbt    = '0;
	ex_tag       = '0;
	if (ew >= 0) begin
		e_exe_pbt    = m_target[es][ew];
		ex_tag       = m_tag[es][ew][`TAG_W-1:0];
		e_mispredict = e_active && (e_taken != m_cnt[es][ew][1]);
	end
	if (!e_mispredict)
		e_corr = bp_pkg::CORR_NONE;
	else if (e_taken)
		e_corr = bp_pkg::CORR_PBT;
	else
		e_corr = bp_pkg::CORR_CNI;
	// compressed branches are one halfword long
	e_exe_cni = {ex_tag, exe_pc[`SET_W-1:0]} + ((exe_c_btype != '0) ? `PC_W'(1) : `PC_W'(2));
	// decode
	is    = int'(id_pc[`SET_W-1:0]);
	iw    = model_find(id_pc, isr_running);
	e_jib = id_is_jump && (iw >= 0);
	if ((iw >= 0) && id_sel_opbr && (id_branchtarget != m_target[is][iw]))
		e_jib = 1'b0;
	e_flush = m_flush_q || e_mispredict;
endfunction

// one advancing clock edge, at most one table write
function automatic void model_step();
	int   is;
	int   iw;
	int   es;
	int   ew;
	int   w;
	logic alloc;
	logic retarget;
	model_expect();
	is       = int'(id_pc[`SET_W-1:0]);
	iw       = model_find(id_pc, isr_running);
	es       = int'(exe_pc[`SET_W-1:0]);
	ew       = model_find(exe_pc, isr_running);
	alloc    = (id_is_jump || id_is_btype) && (iw < 0);
	retarget = 1'b0;
	if (id_is_jump && id_sel_opbr && (iw >= 0))
		retarget = id_branchtarget != m_target[is][iw];
	// the delayed flush is armed from the pre-edge state
	m_flush_q = !m_flush_q && (e_mispredict || (id_is_jump && (iw < 0)) || retarget);
	if (alloc) begin
		w              = m_fifo[is];
		m_valid[is][w]  = 1'b1;
		m_tag[is][w]    = {isr_running, id_pc[`PC_W-1:`SET_W]};
		m_target[is][w] = id_branchtarget;
		m_cnt[is][w]    = id_is_jump ? `CNT_W'(3) : `CNT_W'(1);
		m_fifo[is]      = (w + 1) % `BHT_WAYS;
	end else if (retarget) begin
		m_target[is][iw] = id_branchtarget;
	end else if (e_active && (ew >= 0)) begin
		if (e_taken && (m_cnt[es][ew] != `CNT_W'(3)))
			m_cnt[es][ew] = m_cnt[es][ew] + `CNT_W'(1);
		else if (!e_taken && (m_cnt[es][ew] != `CNT_W'(0)))
			m_cnt[es][ew] = m_cnt[es][ew] - `CNT_W'(1);
	end
endfunction

`endif

// File: verif/tb_branch_predictor.sv
`include "bht_consts.svh"

module tb_branch_predictor;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD      = 20;
	localparam int RESET_CYCLES    = 8;
	localparam int RAND_CYCLES     = 300;
	// directed steps of all tests, rounded up
	localparam int DIRECTED_CYCLES = 60;
	localparam int MARGIN_CYCLES   = 100;
	// four random sections follow the directed steps
	localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + 4 * RAND_CYCLES;

	logic             CLK;
	logic             nrst;
	logic             en;
	logic             isr_running;
	logic             stall;
	logic [`PC_W-1:0] if_pc;
	logic [`PC_W-1:0] id_pc;
	logic [`PC_W-1:0] id_branchtarget;
	logic             id_is_jump;
	logic             id_is_btype;
	logic             id_sel_opbr;
	logic [`PC_W-1:0] exe_pc;
	logic             exe_z;
	logic             exe_less;
	logic [5:0]       exe_btype;
	logic [1:0]       exe_c_btype;
	logic             if_prediction;
	bp_pkg::corr_t    exe_correction;
	logic             flush;
	logic             id_jump_in_bht;
	logic [`PC_W-1:0] if_pbt;
	logic [`PC_W-1:0] exe_pbt;
	logic [`PC_W-1:0] exe_cni;

	int   errors;
	int   tests_run;
	int   tests_failed;
	int   test_start_errors;
	// held freeze levels applied by every idle cycle
	logic force_stall;
	logic force_off;

	`include "bht_model.svh"

	branch_predictor u_dut (
		.CLK             (CLK),
		.nrst            (nrst),
		.en              (en),
		.isr_running     (isr_running),
		.stall           (stall),
		.if_pc           (if_pc),
		.id_pc           (id_pc),
		.id_branchtarget (id_branchtarget),
		.id_is_jump      (id_is_jump),
		.id_is_btype     (id_is_btype),
		.id_sel_opbr     (id_sel_opbr),
		.exe_pc          (exe_pc),
		.exe_z           (exe_z),
		.exe_less        (exe_less),
		.exe_btype       (exe_btype),
		.exe_c_btype     (exe_c_btype),
		.if_prediction   (if_prediction),
		.exe_correction  (exe_correction),
		.flush           (flush),
		.id_jump_in_bht  (id_jump_in_bht),
		.if_pbt          (if_pbt),
		.exe_pbt         (exe_pbt),
		.exe_cni         (exe_cni)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// watchdog sized from the test lengths
	initial begin
		#((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("timeout: tests still running after %0d cycles", TOTAL_CYCLES + MARGIN_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	////////////////////
	// cycle helpers
	////////////////////

	task automatic idle_inputs();
		en              = !force_off;
		stall           = force_stall;
		isr_running     = 1'b0;
		if_pc           = '0;
		id_pc           = '0;
		id_branchtarget = '0;
		id_is_jump      = 1'b0;
		id_is_btype     = 1'b0;
		id_sel_opbr     = 1'b0;
		exe_pc          = '0;
		exe_z           = 1'b0;
		exe_less        = 1'b0;
		exe_btype       = '0;
		exe_c_btype     = '0;
	endtask

	task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
		$display("MISMATCH at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
		errors++;
	endtask

	task automatic check_val(string what, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
			report_mismatch(what, got, exp);
	endtask

	// outputs are compared in the middle of the low phase where inputs have settled
	task automatic settle();
		#(CLK_PERIOD / 4);
		model_expect();
		if (if_prediction !== e_pred)
			report_mismatch("if_prediction", if_prediction, e_pred);
		if (if_pbt !== e_if_pbt)
			report_mismatch("if_pbt", if_pbt, e_if_pbt);
		if (exe_correction !== e_corr)
			report_mismatch("exe_correction", exe_correction, e_corr);
		if (exe_pbt !== e_exe_pbt)
			report_mismatch("exe_pbt", exe_pbt, e_exe_pbt);
		if (exe_cni !== e_exe_cni)
			report_mismatch("exe_cni", exe_cni, e_exe_cni);
		if (flush !== e_flush)
			report_mismatch("flush", flush, e_flush);
		if (id_jump_in_bht !== e_jib)
			report_mismatch("id_jump_in_bht", id_jump_in_bht, e_jib);
	endtask

	// model steps with the dut edge and new inputs go on at the falling edge
	task automatic next_cycle();
		@(posedge CLK);
		if (en && !stall)
			model_step();
		@(negedge CLK);
		idle_inputs();
	endtask

	task automatic decode_cycle(logic [`PC_W-1:0] pc, logic [`PC_W-1:0] tgt, logic jump,
		logic btype, logic opbr, logic isr);
		next_cycle();
		id_pc           = pc;
		if_pc           = pc;
		id_branchtarget = tgt;
		id_is_jump      = jump;
		id_is_btype     = btype;
		id_sel_opbr     = opbr;
		isr_running     = isr;
		settle();
	endtask

	task automatic fetch_cycle(logic [`PC_W-1:0] pc, logic isr);
		next_cycle();
		if_pc       = pc;
		isr_running = isr;
		settle();
	endtask

	task automatic exe_cycle(logic [`PC_W-1:0] pc, logic [5:0] bt, logic [1:0] cbt,
		logic z, logic less);
		next_cycle();
		exe_pc      = pc;
		exe_btype   = bt;
		exe_c_btype = cbt;
		exe_z       = z;
		exe_less    = less;
		settle();
	endtask

	// six tags over four sets so the fifo of a set turns over
	function automatic logic [`PC_W-1:0] pool_pc();
		return {7'($urandom % 6), 4'($urandom % 4)};
	endfunction

	task automatic random_cycle(logic freeze);
		int kind;
		int k;
		next_cycle();
		if (freeze) begin
			stall = ($urandom % 4) == 0;
			en    = ($urandom % 5) != 0;
		end
		isr_running     = ($urandom % 8) == 0;
		if_pc           = pool_pc();
		id_pc           = pool_pc();
		exe_pc          = pool_pc();
		// few targets so register jumps often match
		id_branchtarget = `PC_W'(11'h100 + 11'($urandom % 4));
		kind            = int'($urandom % 4);
		id_is_btype     = kind == 1;
		id_is_jump      = kind >= 2;
		id_sel_opbr     = kind == 3;
		k               = int'($urandom % 10);
		if (k < 6)
			exe_btype = 6'(1 << k);
		else if (k < 8)
			exe_c_btype = 2'(1 << (k - 6));
		exe_z    = ($urandom % 2) != 0;
		exe_less = ($urandom % 2) != 0;
		settle();
	endtask

	task automatic finish_test(string name);
		tests_run++;
		if (errors == test_start_errors) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d mismatches", name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic test_alloc_fetch();
		// five jumps into set 3 so the fifth lands on way 0 again
		for (int k = 1; k <= 5; k++)
			decode_cycle({7'(k), 4'd3}, `PC_W'(11'h100 + k), 1'b1, 1'b0, 1'b0, 1'b0);
		fetch_cycle({7'd1, 4'd3}, 1'b0);
		check_val("evicted if_pbt", if_pbt, 0);
		check_val("evicted if_prediction", if_prediction, 0);
		for (int k = 2; k <= 5; k++) begin
			fetch_cycle({7'(k), 4'd3}, 1'b0);
			check_val("if_pbt", if_pbt, 11'h100 + k);
			check_val("if_prediction", if_prediction, 1);
		end
		finish_test("alloc_fetch");
	endtask

	task automatic test_isr_tag();
		decode_cycle({7'h2a, 4'd6}, 11'h2c5, 1'b1, 1'b0, 1'b0, 1'b1);
		fetch_cycle({7'h2a, 4'd6}, 1'b1);
		check_val("isr if_pbt", if_pbt, 11'h2c5);
		fetch_cycle({7'h2a, 4'd6}, 1'b0);
		check_val("non-isr if_pbt", if_pbt, 0);
		finish_test("isr_tag");
	endtask

	task automatic test_train_correct();
		// branch starts weakly not taken
		decode_cycle({7'h11, 4'd9}, 11'h3a0, 1'b0, 1'b1, 1'b0, 1'b0);
		repeat (3)
			exe_cycle({7'h11, 4'd9}, 6'b100000, 2'b00, 1'b1, 1'b0);
		fetch_cycle({7'h11, 4'd9}, 1'b0);
		check_val("taken saturated prediction", if_prediction, 1);
		// bne with zero set is not taken and steps once past 0
		repeat (4)
			exe_cycle({7'h11, 4'd9}, 6'b010000, 2'b00, 1'b1, 1'b0);
		fetch_cycle({7'h11, 4'd9}, 1'b0);
		check_val("not-taken saturated prediction", if_prediction, 0);
		// c.beqz taken against a zero counter
		exe_cycle({7'h11, 4'd9}, 6'b000000, 2'b10, 1'b1, 1'b0);
		check_val("exe_correction", exe_correction, bp_pkg::CORR_PBT);
		check_val("exe_pbt", exe_pbt, 11'h3a0);
		check_val("exe_cni", exe_cni, 11'h11a);
		repeat (RAND_CYCLES)
			random_cycle(1'b0);
		finish_test("train_correct");
	endtask

	task automatic test_flush();
		repeat (2)
			fetch_cycle('0, 1'b0);
		decode_cycle({7'h40, 4'd1}, 11'h055, 1'b1, 1'b0, 1'b0, 1'b0);
		check_val("flush in allocation cycle", flush, 0);
		fetch_cycle('0, 1'b0);
		check_val("flush after allocation", flush, 1);
		fetch_cycle('0, 1'b0);
		check_val("flush two after allocation", flush, 0);
		// taken branch on a miss is a misprediction
		exe_cycle({7'h41, 4'd2}, 6'b100000, 2'b00, 1'b1, 1'b0);
		check_val("flush on mispredict", flush, 1);
		fetch_cycle('0, 1'b0);
		check_val("flush held", flush, 1);
		fetch_cycle('0, 1'b0);
		check_val("flush released", flush, 0);
		repeat (RAND_CYCLES)
			random_cycle(1'b0);
		finish_test("flush");
	endtask

	task automatic test_jump_retarget();
		decode_cycle({7'h22, 4'd12}, 11'h0f0, 1'b1, 1'b0, 1'b1, 1'b0);
		decode_cycle({7'h22, 4'd12}, 11'h0f0, 1'b1, 1'b0, 1'b1, 1'b0);
		check_val("known jump", id_jump_in_bht, 1);
		decode_cycle({7'h22, 4'd12}, 11'h1e0, 1'b1, 1'b0, 1'b1, 1'b0);
		check_val("changed register jump", id_jump_in_bht, 0);
		fetch_cycle({7'h22, 4'd12}, 1'b0);
		check_val("retargeted if_pbt", if_pbt, 11'h1e0);
		check_val("flush after retarget", flush, 1);
		repeat (RAND_CYCLES)
			random_cycle(1'b0);
		finish_test("jump_retarget");
	endtask

	task automatic test_stall_enable();
		force_stall = 1'b1;
		decode_cycle({7'h33, 4'd5}, 11'h077, 1'b1, 1'b0, 1'b0, 1'b0);
		fetch_cycle({7'h33, 4'd5}, 1'b0);
		check_val("if_pbt after stalled allocation", if_pbt, 0);
		force_stall = 1'b0;
		force_off   = 1'b1;
		decode_cycle({7'h33, 4'd5}, 11'h077, 1'b1, 1'b0, 1'b0, 1'b0);
		force_off   = 1'b0;
		fetch_cycle({7'h33, 4'd5}, 1'b0);
		check_val("if_pbt after disabled allocation", if_pbt, 0);
		repeat (RAND_CYCLES)
			random_cycle(1'b1);
		finish_test("stall_enable");
	endtask

	initial begin
		void'($urandom(2752));
		errors            = 0;
		tests_run         = 0;
		tests_failed      = 0;
		test_start_errors = 0;
		force_stall       = 1'b0;
		force_off         = 1'b0;
		nrst              = 1'b0;
		idle_inputs();
		model_reset();
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		nrst = 1'b1;
		test_alloc_fetch();
		test_isr_tag();
		test_train_correct();
		test_flush();
		test_jump_retarget();
		test_stall_enable();
		$display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: flist.f
+incdir+hw
+incdir+verif
hw/bp_pkg.sv
hw/bht_hit_if.sv
hw/bht_lookup.sv
hw/bht_store.sv
hw/branch_resolve.sv
hw/flush_ctrl.sv
hw/branch_predictor.sv
verif/tb_branch_predictor.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_branch_predictor
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
